//--- alu.sv
`default_nettype none

module alu
    import cpuCtrlPkg::*;
(
    input  wire  [31:0] a,
    input  wire  [31:0] b,
    input  wire  [4:0]  aluCtr,
    output logic [31:0] result,
    output logic        zero,
    output logic        lessThan
);

    logic [4:0] shamt;
    logic       sLess;
    logic       uLess;

    assign shamt = b[4:0];
    assign sLess = $signed(a) < $signed(b);
    assign uLess = a < b;

    // flags for the branch unit
    assign zero     = (a == b);
    assign lessThan = (aluCtr == ALU_SLTU) ? uLess : sLess;

    always_comb begin
        case (aluCtr)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_SLL:   result = a << shamt;
            ALU_SLT:   result = {31'b0, sLess};
            ALU_SLTU:  result = {31'b0, uLess};
            ALU_XOR:   result = a ^ b;
            ALU_SRL:   result = a >> shamt;
            ALU_SRA:   result = $unsigned($signed(a) >>> shamt);
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_COPYB: result = b;
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- branchCond.sv
`default_nettype none

module branchCond
    import cpuCtrlPkg::*;
(
    input  wire  [2:0] branch,
    input  wire        zero,
    input  wire        lessThan,
    output logic       takeTarget
);

    // signedness was already chosen by the alu op
    always_comb begin
        case (branch)
            BR_JAL:  takeTarget = 1'b1;
            BR_JALR: takeTarget = 1'b1;
            BR_EQ:   takeTarget = zero;
            BR_NE:   takeTarget = !zero;
            BR_LT:   takeTarget = lessThan;
            BR_GE:   takeTarget = !lessThan;
            default: takeTarget = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- cpuChecker.sv
`default_nettype none

module cpuChecker
    import rvIsaPkg::*;
(
    input  wire         clk,
    input  wire         rstN,
    input  wire  [31:0] pc,
    input  wire  [31:0] inst,
    input  wire  [31:0] dmemAddr,
    input  wire  [31:0] dmemWdata,
    input  wire  [3:0]  dmemByteEn,
    input  wire         dmemWe,
    input  wire         halted,
    input  wire         illegal,
    output logic [31:0] errorCount
);

    timeunit 1ns;
    timeprecision 1ps;

    // expected effect of one instruction
    typedef struct packed {
        logic [31:0] nextPc;
        logic        storeEn;
        logic [31:0] storeAddr;
        logic [31:0] storeData;
        logic [3:0]  storeBe;
        logic        rdWe;
        logic [4:0]  rd;
        logic [31:0] rdVal;
        logic        halt;
        logic        illeg;
    } stepT;

    // architectural state of the model
    logic [31:0] regs [0:31];
    logic [31:0] refRam [0:255];
    logic [31:0] mPc;
    logic        mHalted;
    logic        mIllegal;
    int          resetCycles;

    initial begin
        errorCount  = 0;
        resetCycles = 0;
    end

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic stepT refStep(input logic [31:0] curPc, input logic [31:0] w);
        stepT        s;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] addr;
        logic [31:0] lane;
        logic        take;
        s      = '0;
        s.nextPc = curPc + 32'd4;
        s.rd   = w[11:7];
        f3     = w[14:12];
        a      = regs[w[19:15]];
        b      = regs[w[24:20]];
        immI   = {{20{w[31]}}, w[31:20]};
        immS   = {{20{w[31]}}, w[31:25], w[11:7]};
        immB   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        immU   = {w[31:12], 12'b0};
        immJ   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        take   = 1'b0;
        case (w[6:0])
            OP_LUI: begin
                s.rdWe  = 1'b1;
                s.rdVal = immU;
            end
            OP_AUIPC: begin
                s.rdWe  = 1'b1;
                s.rdVal = curPc + immU;
            end
            OP_JAL: begin
                s.rdWe   = 1'b1;
                s.rdVal  = curPc + 32'd4;
                s.nextPc = curPc + immJ;
            end
            OP_JALR: begin
                s.rdWe   = 1'b1;
                s.rdVal  = curPc + 32'd4;
                s.nextPc = (a + immI) & ~32'd1;
            end
            OP_BRANCH: begin
                case (f3)
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = $signed(a) < $signed(b);
                    3'd5: take = $signed(a) >= $signed(b);
                    3'd6: take = a < b;
                    3'd7: take = a >= b;
                    default: s.illeg = 1'b1;
                endcase
                if (take) begin
                    s.nextPc = curPc + immB;
                end
            end
            OP_LOAD: begin
                addr    = a + immI;
                lane    = refRam[addr[9:2]] >> {addr[1:0], 3'b000};
                s.rdWe  = 1'b1;
                case (f3)
                    3'd0: s.rdVal = {{24{lane[7]}}, lane[7:0]};
                    3'd1: s.rdVal = {{16{lane[15]}}, lane[15:0]};
                    3'd4: s.rdVal = {24'b0, lane[7:0]};
                    3'd5: s.rdVal = {16'b0, lane[15:0]};
                    default: s.rdVal = refRam[addr[9:2]];
                endcase
            end
            OP_STORE: begin
                addr        = a + immS;
                s.storeEn   = 1'b1;
                s.storeAddr = {addr[31:2], 2'b00};
                case (f3)
                    3'd0: begin
                        s.storeData = {24'b0, b[7:0]} << {addr[1:0], 3'b000};
                        s.storeBe   = 4'b0001 << addr[1:0];
                    end
                    3'd1: begin
                        s.storeData = {16'b0, b[15:0]} << {addr[1:0], 3'b000};
                        s.storeBe   = 4'b0011 << addr[1:0];
                    end
                    default: begin
                        s.storeData = b;
                        s.storeBe   = 4'b1111;
                    end
                endcase
            end
            OP_IMM: begin
                s.rdWe  = 1'b1;
                s.rdVal = aluRef(f3, f3 == 3'd5 && w[30], a, immI);
            end
            OP_REG: begin
                s.rdWe  = 1'b1;
                s.rdVal = aluRef(f3, w[30], a, b);
            end
            OP_SYSTEM: begin
                // ecall does nothing here
                if (w[19:7] != 13'd0) begin
                    s.illeg = 1'b1;
                end else if (w[31:20] == EBREAK_IMM) begin
                    s.halt = 1'b1;
                end else if (w[31:20] != 12'd0) begin
                    s.illeg = 1'b1;
                end
            end
            default: s.illeg = 1'b1;
        endcase
        if (s.illeg) begin
            s.halt    = 1'b1;
            s.rdWe    = 1'b0;
            s.storeEn = 1'b0;
        end
        if (s.halt) begin
            s.nextPc = curPc;
        end
        return s;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h expected %h (model pc %h)", name, got, exp, mPc);
            errorCount = errorCount + 1;
        end
    endtask

    always @(posedge clk) begin
        stepT        s;
        logic [31:0] mask;
        if (!rstN) begin
            // first reset edge may still see unknown state
            if (resetCycles > 0) begin
                checkValue("pc", pc, 32'd0);
                checkValue("halted", halted, 32'd0);
                checkValue("illegal", illegal, 32'd0);
                checkValue("dmemWe", dmemWe, 32'd0);
            end
            resetCycles = resetCycles + 1;
            mPc      = 32'd0;
            mHalted  = 1'b0;
            mIllegal = 1'b0;
            for (int i = 0; i < 32; i++) begin
                regs[i] = 32'd0;
            end
        end else begin
            resetCycles = 0;
            checkValue("pc", pc, mPc);
            checkValue("halted", halted, mHalted);
            checkValue("illegal", illegal, mIllegal);
            if (mHalted) begin
                checkValue("dmemWe", dmemWe, 32'd0);
            end else begin
                s = refStep(mPc, inst);
                checkValue("dmemWe", dmemWe, s.storeEn);
                if (s.storeEn && dmemWe === 1'b1) begin
                    mask = {{8{s.storeBe[3]}}, {8{s.storeBe[2]}},
                            {8{s.storeBe[1]}}, {8{s.storeBe[0]}}};
                    checkValue("dmemAddr", dmemAddr, s.storeAddr);
                    checkValue("dmemByteEn", dmemByteEn, s.storeBe);
                    checkValue("dmemWdata", dmemWdata & mask, s.storeData & mask);
                end
                if (s.rdWe && s.rd != 5'd0) begin
                    regs[s.rd] = s.rdVal;
                end
                if (s.storeEn) begin
                    for (int i = 0; i < 4; i++) begin
                        if (s.storeBe[i]) begin
                            refRam[s.storeAddr[9:2]][8*i +: 8] = s.storeData[8*i +: 8];
                        end
                    end
                end
                mPc      = s.nextPc;
                mHalted  = s.halt;
                mIllegal = s.illeg;
            end
        end
    end

endmodule

`default_nettype wire

//--- cpuCore.sv
`default_nettype none

module cpuCore
    import cpuCtrlPkg::*;
(
    input  wire         clk,
    input  wire         rstN,
    input  wire  [31:0] inst,
    input  wire  [31:0] dmemRdata,
    output logic [31:0] pc,
    output logic [31:0] dmemAddr,
    output logic [31:0] dmemWdata,
    output logic [3:0]  dmemByteEn,
    output logic        dmemWe,
    output logic        halted,
    output logic        illegal
);

    logic [2:0]  extOp;
    logic        regWr;
    logic [1:0]  aluASrc;
    logic [1:0]  aluBSrc;
    logic [4:0]  aluCtr;
    logic [2:0]  branch;
    logic        memToReg;
    logic        memWr;
    logic [2:0]  memOp;
    logic [1:0]  instStatus;
    logic [31:0] imm;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] rdData;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic        zero;
    logic        lessThan;
    logic        takeTarget;
    logic [31:0] target;
    logic [31:0] pcNext;
    logic [1:0]  byteOff;
    logic [31:0] rdShift;
    logic [31:0] loadData;

    ctrlGen u_ctrl (
        .inst       (inst),
        .extOp      (extOp),
        .regWr      (regWr),
        .aluASrc    (aluASrc),
        .aluBSrc    (aluBSrc),
        .aluCtr     (aluCtr),
        .branch     (branch),
        .memToReg   (memToReg),
        .memWr      (memWr),
        .memOp      (memOp),
        .instStatus (instStatus)
    );

    immGen u_imm (
        .inst  (inst),
        .extOp (extOp),
        .imm   (imm)
    );

    regFile u_rf (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (inst[19:15]),
        .rs2Addr (inst[24:20]),
        .rdAddr  (inst[11:7]),
        .rdData  (rdData),
        .rdWe    (regWr && !halted),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    // operand muxes
    assign aluA = (aluASrc == SRC_A_PC) ? pc : rs1Data;

    always_comb begin
        case (aluBSrc)
            SRC_B_IMM:  aluB = imm;
            SRC_B_FOUR: aluB = 32'd4;
            default:    aluB = rs2Data;
        endcase
    end

    alu u_alu (
        .a        (aluA),
        .b        (aluB),
        .aluCtr   (aluCtr),
        .result   (aluResult),
        .zero     (zero),
        .lessThan (lessThan)
    );

    branchCond u_br (
        .branch     (branch),
        .zero       (zero),
        .lessThan   (lessThan),
        .takeTarget (takeTarget)
    );

    // alu is busy with the link value or the compare, so the target has its own adder
    assign target = (branch == BR_JALR) ? ((rs1Data + imm) & ~32'd1) : (pc + imm);
    assign pcNext = takeTarget ? target : pc + 32'd4;

    // pc and sticky status
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc      <= '0;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else if (!halted) begin
            if (instStatus == ST_RUN) begin
                pc <= pcNext;
            end else begin
                halted <= 1'b1;
            end
            if (instStatus == ST_ILLEGAL) begin
                illegal <= 1'b1;
            end
        end
    end

    // memory side, word address plus lane offset
    assign byteOff  = aluResult[1:0];
    assign dmemAddr = {aluResult[31:2], 2'b00};
    assign dmemWe   = memWr && !halted && rstN;

    // memOp[1:0] is the size, memOp[2] means zero-extend
    always_comb begin
        case (memOp[1:0])
            2'b00: begin
                dmemWdata  = {4{rs2Data[7:0]}};
                dmemByteEn = 4'b0001 << byteOff;
            end
            2'b01: begin
                dmemWdata  = {2{rs2Data[15:0]}};
                dmemByteEn = byteOff[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dmemWdata  = rs2Data;
                dmemByteEn = 4'b1111;
            end
        endcase
    end

    // bring the addressed lane down to bit 0
    assign rdShift = dmemRdata >> {byteOff, 3'b000};

    always_comb begin
        case (memOp[1:0])
            2'b00: begin
                loadData = memOp[2] ? {24'b0, rdShift[7:0]}
                                    : {{24{rdShift[7]}}, rdShift[7:0]};
            end
            2'b01: begin
                loadData = memOp[2] ? {16'b0, rdShift[15:0]}
                                    : {{16{rdShift[15]}}, rdShift[15:0]};
            end
            default: loadData = dmemRdata;
        endcase
    end

    assign rdData = memToReg ? loadData : aluResult;

endmodule

`default_nettype wire

//--- cpuCore_sva.sv
`default_nettype none

module cpuCoreSva (
    input wire        clk,
    input wire        rstN,
    input wire [31:0] pc,
    input wire        dmemWe,
    input wire        halted
);

    timeunit 1ns;
    timeprecision 1ps;

    noWriteWhileHalted: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !dmemWe)
        else $error("memory write enabled while the core is halted");

    pcWordAligned: assert property (@(posedge clk) disable iff (!rstN)
        pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // halt is sticky until reset
    haltedSticky: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted)
        else $error("halted dropped without a reset");

endmodule

bind cpuCore cpuCoreSva u_sva (
    .clk    (clk),
    .rstN   (rstN),
    .pc     (pc),
    .dmemWe (dmemWe),
    .halted (halted)
);

`default_nettype wire

//--- cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;

    // immediate types
    localparam logic [2:0] EXT_I = 3'b000;
    localparam logic [2:0] EXT_U = 3'b001;
    localparam logic [2:0] EXT_S = 3'b010;
    localparam logic [2:0] EXT_B = 3'b011;
    localparam logic [2:0] EXT_J = 3'b100;
    localparam logic [2:0] EXT_N = 3'b101;
    localparam logic [2:0] EXT_R = 3'b111;

    // alu ops, {funct7[5], funct7[0], funct3}
    localparam logic [4:0] ALU_ADD   = 5'b00000;
    localparam logic [4:0] ALU_SUB   = 5'b10000;
    localparam logic [4:0] ALU_SLL   = 5'b00001;
    localparam logic [4:0] ALU_SLT   = 5'b00010;
    localparam logic [4:0] ALU_SLTU  = 5'b00011;
    localparam logic [4:0] ALU_XOR   = 5'b00100;
    localparam logic [4:0] ALU_SRL   = 5'b00101;
    localparam logic [4:0] ALU_SRA   = 5'b10101;
    localparam logic [4:0] ALU_OR    = 5'b00110;
    localparam logic [4:0] ALU_AND   = 5'b00111;
    localparam logic [4:0] ALU_COPYB = 5'b11000;

    // branch kinds
    localparam logic [2:0] BR_NONE = 3'b000;
    localparam logic [2:0] BR_JAL  = 3'b001;
    localparam logic [2:0] BR_JALR = 3'b010;
    localparam logic [2:0] BR_EQ   = 3'b100;
    localparam logic [2:0] BR_NE   = 3'b101;
    localparam logic [2:0] BR_LT   = 3'b110;
    localparam logic [2:0] BR_GE   = 3'b111;

    // alu operand selects
    localparam logic [1:0] SRC_A_RS1  = 2'b00;
    localparam logic [1:0] SRC_A_PC   = 2'b01;
    localparam logic [1:0] SRC_B_RS2  = 2'b00;
    localparam logic [1:0] SRC_B_IMM  = 2'b01;
    localparam logic [1:0] SRC_B_FOUR = 2'b10;

    // instruction status
    localparam logic [1:0] ST_RUN     = 2'b00;
    localparam logic [1:0] ST_ILLEGAL = 2'b01;
    localparam logic [1:0] ST_EBREAK  = 2'b10;

endpackage

`default_nettype wire

//--- ctrlGen.sv
`default_nettype none

module ctrlGen
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  wire  [XLEN-1:0] inst,
    output logic [2:0]      extOp,
    output logic            regWr,
    output logic [1:0]      aluASrc,
    output logic [1:0]      aluBSrc,
    output logic [4:0]      aluCtr,
    output logic [2:0]      branch,
    output logic            memToReg,
    output logic            memWr,
    output logic [2:0]      memOp,
    output logic [1:0]      instStatus
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        // safe defaults, no writes and no jump
        extOp      = EXT_N;
        regWr      = 1'b0;
        aluASrc    = SRC_A_RS1;
        aluBSrc    = SRC_B_RS2;
        aluCtr     = ALU_ADD;
        branch     = BR_NONE;
        memToReg   = 1'b0;
        memWr      = 1'b0;
        memOp      = 3'b000;
        instStatus = ST_RUN;
        case (opcode)
            OP_REG: begin
                extOp  = EXT_R;
                regWr  = 1'b1;
                aluCtr = {funct7[5], funct7[0], funct3};
            end
            OP_IMM: begin
                extOp   = EXT_I;
                regWr   = 1'b1;
                aluBSrc = SRC_B_IMM;
                // only srai keeps the arithmetic bit, imm bits would corrupt the rest
                aluCtr  = (funct3 == F3_SR && funct7[5]) ? {2'b10, funct3} : {2'b00, funct3};
            end
            OP_LUI: begin
                extOp   = EXT_U;
                regWr   = 1'b1;
                aluBSrc = SRC_B_IMM;
                aluCtr  = ALU_COPYB;
            end
            OP_AUIPC: begin
                extOp   = EXT_U;
                regWr   = 1'b1;
                aluASrc = SRC_A_PC;
                aluBSrc = SRC_B_IMM;
            end
            OP_JAL: begin
                extOp   = EXT_J;
                regWr   = 1'b1;
                aluASrc = SRC_A_PC;
                aluBSrc = SRC_B_FOUR;
                branch  = BR_JAL;
            end
            OP_JALR: begin
                extOp   = EXT_I;
                regWr   = 1'b1;
                aluASrc = SRC_A_PC;
                aluBSrc = SRC_B_FOUR;
                branch  = BR_JALR;
            end
            OP_BRANCH: begin
                extOp = EXT_B;
                // alu compares rs1 and rs2, branchCond reads the flags
                case (funct3)
                    F3_BEQ: begin
                        branch = BR_EQ;
                        aluCtr = ALU_SLT;
                    end
                    F3_BNE: begin
                        branch = BR_NE;
                        aluCtr = ALU_SLT;
                    end
                    F3_BLT: begin
                        branch = BR_LT;
                        aluCtr = ALU_SLT;
                    end
                    F3_BGE: begin
                        branch = BR_GE;
                        aluCtr = ALU_SLT;
                    end
                    F3_BLTU: begin
                        branch = BR_LT;
                        aluCtr = ALU_SLTU;
                    end
                    F3_BGEU: begin
                        branch = BR_GE;
                        aluCtr = ALU_SLTU;
                    end
                    default: instStatus = ST_ILLEGAL;
                endcase
            end
            OP_LOAD: begin
                extOp    = EXT_I;
                regWr    = 1'b1;
                aluBSrc  = SRC_B_IMM;
                memToReg = 1'b1;
                memOp    = funct3;
            end
            OP_STORE: begin
                extOp   = EXT_S;
                aluBSrc = SRC_B_IMM;
                memWr   = 1'b1;
                memOp   = funct3;
            end
            OP_SYSTEM: begin
                extOp = EXT_I;
                // ecall passes as a no-op, anything else but ebreak traps
                if (inst[19:7] != '0) begin
                    instStatus = ST_ILLEGAL;
                end else if (inst[31:20] == EBREAK_IMM) begin
                    instStatus = ST_EBREAK;
                end else if (inst[31:20] != ECALL_IMM) begin
                    instStatus = ST_ILLEGAL;
                end
            end
            default: instStatus = ST_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

//--- immGen.sv
`default_nettype none

module immGen
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  wire  [XLEN-1:0] inst,
    input  wire  [2:0]      extOp,
    output logic [XLEN-1:0] imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (extOp)
            EXT_I: imm = {{20{sign}}, inst[31:20]};
            EXT_S: imm = {{20{sign}}, inst[31:25], inst[11:7]};
            // b and j offsets are in halfwords, bit 0 is always zero
            EXT_B: imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            EXT_U: imm = {inst[31:12], 12'b0};
            EXT_J: imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- list.f
rvIsaPkg.sv
cpuCtrlPkg.sv
ctrlGen.sv
immGen.sv
alu.sv
regFile.sv
branchCond.sv
cpuCore.sv
cpuCore_sva.sv
cpuChecker.sv
tbCpu.sv

//--- regFile.sv
`default_nettype none

module regFile (
    input  wire         clk,
    input  wire         rstN,
    input  wire  [4:0]  rs1Addr,
    input  wire  [4:0]  rs2Addr,
    input  wire  [4:0]  rdAddr,
    input  wire  [31:0] rdData,
    input  wire         rdWe,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWe && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? 32'd0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? 32'd0 : regs[rs2Addr];

endmodule

`default_nettype wire

//--- rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // data and address width
    localparam int XLEN = 32;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // right shifts share funct3, funct7[5] picks arithmetic
    localparam logic [2:0] F3_SR = 3'b101;

    // system immediates, inst[31:20]
    localparam logic [11:0] ECALL_IMM  = 12'h000;
    localparam logic [11:0] EBREAK_IMM = 12'h001;

endpackage

`default_nettype wire

//--- tbCpu.sv
`default_nettype none

module tbCpu
    import rvIsaPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        rstN;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWdata;
    logic [3:0]  dmemByteEn;
    logic        dmemWe;
    logic [31:0] dmemRdata;
    logic        halted;
    logic        illegal;
    logic [31:0] errorCount;
    logic [31:0] progRom [0:63];
    logic [31:0] dataRam [0:255];
    logic [31:0] lfsrState = 32'hc023_6f48;
    int          progLen;
    int          storeOff;
    int          timeouts = 0;

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
    end

    always #20 clk = ~clk;

    cpuCore u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .inst       (inst),
        .dmemRdata  (dmemRdata),
        .pc         (pc),
        .dmemAddr   (dmemAddr),
        .dmemWdata  (dmemWdata),
        .dmemByteEn (dmemByteEn),
        .dmemWe     (dmemWe),
        .halted     (halted),
        .illegal    (illegal)
    );

    cpuChecker u_chk (
        .clk        (clk),
        .rstN       (rstN),
        .pc         (pc),
        .inst       (inst),
        .dmemAddr   (dmemAddr),
        .dmemWdata  (dmemWdata),
        .dmemByteEn (dmemByteEn),
        .dmemWe     (dmemWe),
        .halted     (halted),
        .illegal    (illegal),
        .errorCount (errorCount)
    );

    // combinational memories
    assign inst      = progRom[pc[7:2]];
    assign dmemRdata = dataRam[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (rstN && dmemWe) begin
            for (int i = 0; i < 4; i++) begin
                if (dmemByteEn[i]) begin
                    dataRam[dmemAddr[9:2]][8*i +: 8] <= dmemWdata[8*i +: 8];
                end
            end
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3);
        // rd x10, rs1 x2, rs2 x3
        return {f7, 5'd3, 5'd2, f3, 5'd10, OP_REG};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] w);
        progRom[progLen] = w;
        progLen = progLen + 1;
    endtask

    // result in x10 goes to the next slot above x1
    task automatic emitStore(input logic [31:0] w);
        emit(w);
        emit(encS(storeOff[11:0], 5'd10, 5'd1, 3'd2));
        storeOff = storeOff + 4;
    endtask

    task automatic buildArith();
        storeOff = 0;
        emit(encI(12'h200, 5'd0, 3'd0, 5'd1, OP_IMM));
        emit({20'h87654, 5'd2, OP_LUI});
        emit(encI(12'h321, 5'd2, 3'd0, 5'd2, OP_IMM));
        emit(encI(12'hff3, 5'd0, 3'd0, 5'd3, OP_IMM));
        emitStore(encR(7'h00, 3'd0));
        emitStore(encR(7'h20, 3'd0));
        emitStore(encR(7'h00, 3'd1));
        emitStore(encR(7'h00, 3'd2));
        emitStore(encR(7'h00, 3'd3));
        emitStore(encR(7'h00, 3'd4));
        emitStore(encR(7'h00, 3'd5));
        emitStore(encR(7'h20, 3'd5));
        emitStore(encR(7'h00, 3'd6));
        emitStore(encR(7'h00, 3'd7));
        emitStore(encI(12'hf9c, 5'd2, 3'd0, 5'd10, OP_IMM));
        emitStore(encI(12'h005, 5'd2, 3'd2, 5'd10, OP_IMM));
        emitStore(encI(12'hfff, 5'd1, 3'd3, 5'd10, OP_IMM));
        emitStore(encI(12'h5a5, 5'd2, 3'd4, 5'd10, OP_IMM));
        emitStore(encI(12'h0f0, 5'd3, 3'd6, 5'd10, OP_IMM));
        emitStore(encI(12'hf0f, 5'd2, 3'd7, 5'd10, OP_IMM));
        emitStore(encI(12'h007, 5'd2, 3'd1, 5'd10, OP_IMM));
        emitStore(encI(12'h009, 5'd2, 3'd5, 5'd10, OP_IMM));
        emitStore(encI(12'h409, 5'd2, 3'd5, 5'd10, OP_IMM));
        emitStore({20'hfedcb, 5'd10, OP_LUI});
        emitStore({20'h00012, 5'd10, OP_AUIPC});
        emit(encI(EBREAK_IMM, 5'd0, 3'd0, 5'd0, OP_SYSTEM));
    endtask

    task automatic buildMemBranch();
        int jalrTarget;
        emit(encI(12'h100, 5'd0, 3'd0, 5'd1, OP_IMM));
        emit({20'h87654, 5'd2, OP_LUI});
        emit(encI(12'h321, 5'd2, 3'd0, 5'd2, OP_IMM));
        // every byte lane, both halves, one word
        emit(encS(12'd0, 5'd2, 5'd1, 3'd0));
        emit(encS(12'd5, 5'd2, 5'd1, 3'd0));
        emit(encS(12'd10, 5'd2, 5'd1, 3'd0));
        emit(encS(12'd15, 5'd2, 5'd1, 3'd0));
        emit(encS(12'd16, 5'd2, 5'd1, 3'd1));
        emit(encS(12'd22, 5'd2, 5'd1, 3'd1));
        emit(encS(12'd24, 5'd2, 5'd1, 3'd2));
        storeOff = 'h080;
        for (int k = 0; k < 4; k++) begin
            emitStore(encI(12'h040 + k[11:0], 5'd1, 3'd0, 5'd10, OP_LOAD));
            emitStore(encI(12'h040 + k[11:0], 5'd1, 3'd4, 5'd10, OP_LOAD));
        end
        for (int k = 0; k < 4; k += 2) begin
            emitStore(encI(12'h040 + k[11:0], 5'd1, 3'd1, 5'd10, OP_LOAD));
            emitStore(encI(12'h040 + k[11:0], 5'd1, 3'd5, 5'd10, OP_LOAD));
        end
        emitStore(encI(12'h040, 5'd1, 3'd2, 5'd10, OP_LOAD));
        emit(encI(12'hff3, 5'd0, 3'd0, 5'd3, OP_IMM));
        emit(encI(12'h005, 5'd0, 3'd0, 5'd4, OP_IMM));
        // taken branches skip one nop
        emit(encB(13'd8, 5'd4, 5'd4, 3'd0));
        emit(encI(12'h001, 5'd0, 3'd0, 5'd10, OP_IMM));
        emit(encB(13'd8, 5'd4, 5'd4, 3'd1));
        emit(encB(13'd8, 5'd4, 5'd3, 3'd4));
        emit(encI(12'h001, 5'd0, 3'd0, 5'd10, OP_IMM));
        emit(encB(13'd8, 5'd4, 5'd3, 3'd5));
        emit(encB(13'd8, 5'd4, 5'd3, 3'd6));
        emit(encB(13'd8, 5'd4, 5'd3, 3'd7));
        emit(encI(12'h001, 5'd0, 3'd0, 5'd10, OP_IMM));
        emit(encJ(21'd8, 5'd5));
        emit(encI(12'h001, 5'd0, 3'd0, 5'd10, OP_IMM));
        // odd target checks that bit 0 is cleared
        jalrTarget = (progLen + 3) * 4;
        emit(encI(jalrTarget[11:0] + 12'd1, 5'd0, 3'd0, 5'd6, OP_JALR));
        emit(encI(12'h001, 5'd0, 3'd0, 5'd10, OP_IMM));
        emit(encI(12'h001, 5'd0, 3'd0, 5'd10, OP_IMM));
        emit(encS(12'h0c0, 5'd5, 5'd1, 3'd2));
        emit(encS(12'h0c4, 5'd6, 5'd1, 3'd2));
        emit(encI(EBREAK_IMM, 5'd0, 3'd0, 5'd0, OP_SYSTEM));
    endtask

    task automatic buildIllegal();
        // store at pc 0, must stay off while reset holds
        emit(encS(12'd0, 5'd0, 5'd0, 3'd2));
        emit(encI(12'h100, 5'd0, 3'd0, 5'd1, OP_IMM));
        emit(encI(12'h007, 5'd0, 3'd0, 5'd2, OP_IMM));
        emit(32'hffff_ffff);
        emit(encS(12'd0, 5'd2, 5'd1, 3'd2));
    endtask

    task automatic runProgram(input int which);
        int cycles;
        rstN <= 1'b0;
        @(posedge clk);
        progLen = 0;
        for (int i = 0; i < 64; i++) begin
            progRom[i] = encI(12'd0, 5'd0, 3'd0, 5'd0, OP_IMM);
        end
        case (which)
            0: buildArith();
            1: buildMemBranch();
            default: buildIllegal();
        endcase
        // one lfsr step per data bit
        for (int w = 0; w < 256; w++) begin
            for (int b = 0; b < 32; b++) begin
                lfsrState = lfsrNext(lfsrState);
                dataRam[w][b] = lfsrState[0];
            end
            u_chk.refRam[w] = dataRam[w];
        end
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        cycles = 0;
        while (halted !== 1'b1 && cycles < 500) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (halted !== 1'b1) begin
            timeouts = timeouts + 1;
            $display("timeout: core did not halt in program run %0d", which);
        end
        // watch pc hold and writes stay off
        repeat (4) @(posedge clk);
    endtask

    initial begin
        runProgram(0);
        runProgram(1);
        runProgram(2);
        $display("checks done: %0d errors, %0d timeouts", errorCount, timeouts);
        if (errorCount == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
